// File: vlog.f
+incdir+tb
rtl/mips_pkg.sv
rtl/control.sv
rtl/alu.sv
rtl/regfile.sv
rtl/data_mem.sv
rtl/mips_core.sv
tb/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_mips_core --Mdir "$OBJ" -o tb_mips_core
if [ $? -ne 0 ]; then
	echo "run_sim: Verilator build failed"
	exit 1
fi

"./$OBJ/tb_mips_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "run_sim: simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "run_sim: failure reported, see $LOG"
	exit 1
fi

echo "run_sim: no failure found in $LOG"
exit 0

// File: tb/mips_model.svh
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

logic [XLEN-1:0] model_pc;
logic [XLEN-1:0] model_regs [32];
logic [XLEN-1:0] model_mem [DMEM_WORDS];

function automatic void reset_model();
	model_pc = RESET_PC;
	for (int i = 0; i < 32; i++) begin
		model_regs[i] = '0;
	end
	for (int i = 0; i < DMEM_WORDS; i++) begin
		model_mem[i] = '0;
	end
endfunction

function automatic int word_index(input logic [XLEN-1:0] addr);
	return int'((addr >> 2) % DMEM_WORDS); // memory wraps on the word address.
endfunction

function automatic logic [XLEN-1:0] rtype_result(input logic [5:0] fn,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
	case (fn)
		mips_pkg::FN_ADD, mips_pkg::FN_ADDU: return a + b; // no overflow trap.
		mips_pkg::FN_SUB, mips_pkg::FN_SUBU: return a - b;
		mips_pkg::FN_AND: return a & b;
		mips_pkg::FN_OR:  return a | b;
		mips_pkg::FN_XOR: return a ^ b;
		mips_pkg::FN_NOR: return ~(a | b);
		mips_pkg::FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		default:          return '0; // an unknown funct still writes zero.
	endcase
endfunction

// retires one word and predicts what the core reports the cycle after.
function automatic void step_model(input logic [XLEN-1:0] word,
		output mips_pkg::commit_t c, output mips_pkg::store_t s);
	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic [XLEN-1:0] sx;
	logic [XLEN-1:0] zx;
	logic [XLEN-1:0] res;
	logic [XLEN-1:0] seq_pc;
	logic [XLEN-1:0] next_pc;
	logic [4:0]      dst;
	logic            wr;
	a       = model_regs[word[25:21]];
	b       = model_regs[word[20:16]];
	sx      = {{16{word[15]}}, word[15:0]};
	zx      = {16'h0000, word[15:0]};
	seq_pc  = model_pc + 32'd4;
	next_pc = seq_pc;
	dst     = word[20:16];
	wr      = 1'b1;
	res     = '0;
	c       = '0;
	s       = '0;
	case (word[31:26])
		mips_pkg::OP_RTYPE: begin
			dst = word[15:11];
			res = rtype_result(word[5:0], a, b);
		end
		mips_pkg::OP_ADDI: res = a + sx;
		mips_pkg::OP_SLTI: res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
		mips_pkg::OP_ANDI: res = a & zx;
		mips_pkg::OP_ORI:  res = a | zx;
		mips_pkg::OP_XORI: res = a ^ zx;
		mips_pkg::OP_LUI:  res = {word[15:0], 16'h0000};
		mips_pkg::OP_LW:   res = model_mem[word_index(a + sx)];
		mips_pkg::OP_SW: begin
			wr = 1'b0;
			model_mem[word_index(a + sx)] = b;
			s.valid = 1'b1;
			s.addr  = a + sx;
			s.data  = b;
		end
		mips_pkg::OP_BEQ: begin
			wr = 1'b0;
			if (a == b)
				next_pc = seq_pc + (sx << 2);
		end
		mips_pkg::OP_BNE: begin
			wr = 1'b0;
			if (a != b)
				next_pc = seq_pc + (sx << 2);
		end
		mips_pkg::OP_J: begin
			wr = 1'b0;
			next_pc = {seq_pc[31:28], word[25:0], 2'b00};
		end
		default: wr = 1'b0;
	endcase
	if (wr && dst != 5'd0) begin
		model_regs[dst] = res;
		c.valid = 1'b1;
		c.rd    = dst;
		c.data  = res;
	end
	model_pc = next_pc;
endfunction

`endif

// File: tb/tb_mips_core.sv
module tb_mips_core;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int              XLEN         = mips_pkg::XLEN;
	localparam int              DMEM_WORDS   = 256;
	localparam logic [XLEN-1:0] RESET_PC     = 32'h0000_0400;
	localparam int              PROG_WORDS   = 512;
	localparam int              RESET_CYCLES = 4;
	localparam int              RUN_CYCLES   = 3000;
	localparam int              CLK_PERIOD   = 8;
	localparam int              SEED         = 5;
	localparam int              WATCHDOG_NS  = (RESET_CYCLES + RUN_CYCLES + 20) * CLK_PERIOD;

	logic              clk;
	logic              rst;
	logic [XLEN-1:0]   instr;
	logic [XLEN-1:0]   pc;
	mips_pkg::commit_t commit;
	mips_pkg::store_t  store;

	logic [XLEN-1:0] prog [PROG_WORDS];
	int              pc_errors = 0;
	int              commit_errors = 0;
	int              store_errors = 0;

	`include "mips_model.svh"

	mips_core #(
		.DMEM_WORDS (DMEM_WORDS),
		.RESET_PC   (RESET_PC)
	) u_mips_core (
		.clk    (clk),
		.rst    (rst),
		.instr  (instr),
		.pc     (pc),
		.commit (commit),
		.store  (store)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// past the end of the program the core sees all zeros, an r0 write.
	function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
		int idx;
		if ($isunknown(addr) || addr < RESET_PC)
			return '0;
		idx = int'((addr - RESET_PC) >> 2);
		if (idx >= PROG_WORDS)
			return '0;
		return prog[idx];
	endfunction

	always_comb instr = fetch_word(pc);

	function automatic logic [4:0] pick_reg();
		return 5'($urandom_range(0, 7)); // few registers, so values get reused.
	endfunction

	function automatic logic [5:0] rtype_funct();
		case ($urandom_range(0, 9))
			0:       return mips_pkg::FN_ADD;
			1:       return mips_pkg::FN_ADDU;
			2:       return mips_pkg::FN_SUB;
			3:       return mips_pkg::FN_SUBU;
			4:       return mips_pkg::FN_AND;
			5:       return mips_pkg::FN_OR;
			6:       return mips_pkg::FN_XOR;
			7:       return mips_pkg::FN_NOR;
			8:       return mips_pkg::FN_SLT;
			default: return 6'h3c;
		endcase
	endfunction

	function automatic logic [5:0] imm_opcode();
		case ($urandom_range(0, 4))
			0:       return mips_pkg::OP_ADDI;
			1:       return mips_pkg::OP_ANDI;
			2:       return mips_pkg::OP_ORI;
			3:       return mips_pkg::OP_SLTI;
			default: return mips_pkg::OP_XORI;
		endcase
	endfunction

	function automatic logic [5:0] unknown_opcode();
		case ($urandom_range(0, 3))
			0:       return 6'h01;
			1:       return 6'h03;
			2:       return 6'h1c;
			default: return 6'h3f;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] build_instr();
		int          pick;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
		logic [25:0] target;
		pick   = int'($urandom_range(0, 99));
		rs     = pick_reg();
		rt     = pick_reg();
		imm    = 16'($urandom());
		target = 26'((RESET_PC >> 2) + $urandom_range(0, PROG_WORDS - 1));
		if (pick < 30)
			return {mips_pkg::OP_RTYPE, rs, rt, pick_reg(), 5'd0, rtype_funct()};
		else if (pick < 50)
			return {imm_opcode(), rs, rt, imm};
		else if (pick < 56)
			return {mips_pkg::OP_LUI, 5'd0, rt, imm};
		else if (pick < 66)
			return {mips_pkg::OP_LW, 5'd0, rt, 16'($urandom_range(0, 31) * 4)};
		else if (pick < 76)
			return {mips_pkg::OP_SW, 5'd0, rt, 16'($urandom_range(0, 31) * 4)};
		else if (pick < 88)
			return {($urandom_range(0, 1) != 0) ? mips_pkg::OP_BNE : mips_pkg::OP_BEQ,
				rs, rt, 16'($urandom_range(0, 7))}; // short forward branch.
		else if (pick < 92)
			return {mips_pkg::OP_J, target};
		return {unknown_opcode(), rs, rt, imm};
	endfunction

	task automatic check_pc(input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
		if (actual !== expected) begin
			pc_errors++;
			$display("[ERROR] %0d ns: pc expected %h, actual %h", $time, expected, actual);
		end
	endtask

	task automatic check_commit(input mips_pkg::commit_t expected,
			input mips_pkg::commit_t actual);
		if (actual.valid !== expected.valid || (expected.valid
				&& (actual.rd !== expected.rd || actual.data !== expected.data))) begin
			commit_errors++;
			$display("[ERROR] %0d ns: commit expected valid=%0b rd=%0d data=%h, %s",
				$time, expected.valid, expected.rd, expected.data,
				$sformatf("actual valid=%0b rd=%0d data=%h", actual.valid, actual.rd,
				actual.data));
		end
	endtask

	task automatic check_store(input mips_pkg::store_t expected, input mips_pkg::store_t actual);
		if (actual.valid !== expected.valid || (expected.valid
				&& (actual.addr !== expected.addr || actual.data !== expected.data))) begin
			store_errors++;
			$display("[ERROR] %0d ns: store expected valid=%0b addr=%h data=%h, %s",
				$time, expected.valid, expected.addr, expected.data,
				$sformatf("actual valid=%0b addr=%h data=%h", actual.valid, actual.addr,
				actual.data));
		end
	endtask

	initial begin
		mips_pkg::commit_t exp_commit;
		mips_pkg::store_t  exp_store;
		clk = 1'b0;
		rst = 1'b1;
		void'($urandom(SEED));
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog[i] = build_instr();
		end
		reset_model();
		exp_commit = '0; // nothing is reported straight after reset.
		exp_store  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int n = 0; n <= RUN_CYCLES; n++) begin
			@(negedge clk);
			check_pc(model_pc, pc);
			check_commit(exp_commit, commit);
			check_store(exp_store, store);
			step_model(fetch_word(model_pc), exp_commit, exp_store);
		end
		$display("errors: pc %0d, commit %0d, store %0d", pc_errors, commit_errors, store_errors);
		if (pc_errors + commit_errors + store_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: rtl/mips_core.sv
module mips_core #(
	parameter int                        DMEM_WORDS = 256,
	parameter logic [mips_pkg::XLEN-1:0] RESET_PC   = '0
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [mips_pkg::XLEN-1:0] instr,
	output logic [mips_pkg::XLEN-1:0] pc,
	output mips_pkg::commit_t         commit,
	output mips_pkg::store_t          store
);

	localparam int XLEN = mips_pkg::XLEN;

	logic [5:0]                      opcode;
	logic [5:0]                      funct;
	logic [mips_pkg::REG_ADDR_W-1:0] rs;
	logic [mips_pkg::REG_ADDR_W-1:0] rt;
	logic [mips_pkg::REG_ADDR_W-1:0] rd;
	logic [mips_pkg::REG_ADDR_W-1:0] wdst;
	logic [15:0]                     imm;
	logic [25:0]                     target;

	mips_pkg::ctrl_t ctrl;

	logic [XLEN-1:0] rs_data;
	logic [XLEN-1:0] rt_data;
	logic [XLEN-1:0] imm_sext;
	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_result;
	logic            alu_zero;
	logic [XLEN-1:0] mem_rdata;
	logic [XLEN-1:0] wb_data;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] br_target;
	logic [XLEN-1:0] jmp_target;
	logic [XLEN-1:0] pc_next;
	logic            br_taken;
	logic            commit_en;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign imm    = instr[15:0];
	assign funct  = instr[5:0];
	assign target = instr[25:0];

	control u_control (
		.opcode (opcode),
		.ctrl   (ctrl)
	);

	regfile u_regfile (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (rs),
		.raddr2 (rt),
		.rdata1 (rs_data),
		.rdata2 (rt_data),
		.we     (ctrl.regwrite),
		.waddr  (wdst),
		.wdata  (wb_data)
	);

	assign imm_sext = {{(XLEN-16){imm[15]}}, imm};
	assign imm_ext  = ctrl.zero_ext ? {{(XLEN-16){1'b0}}, imm} : imm_sext;
	assign alu_b    = ctrl.alusrc ? imm_ext : rt_data;
	assign wdst     = ctrl.regdst ? rd : rt;

	alu u_alu (
		.a      (rs_data),
		.b      (alu_b),
		.op     (ctrl.alu_op),
		.funct  (funct),
		.result (alu_result),
		.zero   (alu_zero)
	);

	data_mem #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_data_mem (
		.clk   (clk),
		.rst   (rst),
		.we    (ctrl.memwrite),
		.addr  (alu_result),
		.wdata (rt_data),
		.rdata (mem_rdata)
	);

	assign wb_data = ctrl.memtoreg ? mem_rdata : alu_result;

	assign pc_plus4   = pc + XLEN'(4);
	assign br_target  = pc_plus4 + {imm_sext[XLEN-3:0], 2'b00};
	assign jmp_target = {pc_plus4[XLEN-1:28], target, 2'b00};
	assign br_taken   = ctrl.isbranch && (alu_zero ^ ctrl.branch_ne);
	assign pc_next    = ctrl.isjump ? jmp_target : (br_taken ? br_target : pc_plus4);

	assign commit_en = ctrl.regwrite && (wdst != '0); // r0 writes are not reported.

	always_ff @(posedge clk) begin
		if (rst) begin
			pc           <= RESET_PC;
			commit.valid <= 1'b0;
			store.valid  <= 1'b0;
		end else begin
			pc           <= pc_next;
			commit.valid <= commit_en;
			store.valid  <= ctrl.memwrite;
		end
		commit.rd   <= wdst;
		commit.data <= wb_data;
		store.addr  <= alu_result;
		store.data  <= rt_data;
	end

	// lw drops the low address bits, so a load must sit on a word boundary.
	load_aligned: assert property (@(posedge clk) disable iff (rst)
			ctrl.memtoreg |-> alu_result[1:0] == 2'b00)
		else $error("mips_core: misaligned load from %h", alu_result);

endmodule

// File: rtl/data_mem.sv
module data_mem #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      we,
	input  logic [mips_pkg::XLEN-1:0] addr,
	input  logic [mips_pkg::XLEN-1:0] wdata,
	output logic [mips_pkg::XLEN-1:0] rdata
);

	localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

	logic [mips_pkg::XLEN-1:0] mem [DMEM_WORDS];
	logic [mips_pkg::XLEN-3:0] word_addr;
	logic [IDX_W-1:0]          idx;

	assign word_addr = addr[mips_pkg::XLEN-1:2];
	assign idx       = IDX_W'(word_addr % DMEM_WORDS); // wraps inside the array.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[idx] <= wdata;
		end
	end

	assign rdata = mem[idx];

	// only word accesses exist, so a store must land on a word boundary.
	store_aligned: assert property (@(posedge clk) disable iff (rst) we |-> addr[1:0] == 2'b00)
		else $error("data_mem: misaligned store to %h", addr);

endmodule

// File: rtl/regfile.sv
module regfile (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [mips_pkg::REG_ADDR_W-1:0] raddr1,
	input  logic [mips_pkg::REG_ADDR_W-1:0] raddr2,
	output logic [mips_pkg::XLEN-1:0]       rdata1,
	output logic [mips_pkg::XLEN-1:0]       rdata2,
	input  logic                            we,
	input  logic [mips_pkg::REG_ADDR_W-1:0] waddr,
	input  logic [mips_pkg::XLEN-1:0]       wdata
);

	localparam int NREGS = 2 ** mips_pkg::REG_ADDR_W;

	logic [mips_pkg::XLEN-1:0] regs [NREGS];

	// the model starts from all-zero registers, so reset clears the file.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

// File: rtl/alu.sv
module alu (
	input  logic [mips_pkg::XLEN-1:0] a,
	input  logic [mips_pkg::XLEN-1:0] b,
	input  mips_pkg::alu_op_e         op,
	input  logic [5:0]                funct,
	output logic [mips_pkg::XLEN-1:0] result,
	output logic                      zero
);

	localparam int HALF = mips_pkg::XLEN / 2;

	mips_pkg::alu_op_e          eff_op;
	logic [mips_pkg::XLEN-1:0]  diff;

	assign diff = a - b;
	assign zero = (diff == '0); // branches compare through this flag.

	always_comb begin
		eff_op = op;
		if (op == mips_pkg::ALU_FUNCT) begin
			case (funct)
				mips_pkg::FN_ADD, mips_pkg::FN_ADDU: eff_op = mips_pkg::ALU_ADD;
				mips_pkg::FN_SUB, mips_pkg::FN_SUBU: eff_op = mips_pkg::ALU_SUB;
				mips_pkg::FN_AND: eff_op = mips_pkg::ALU_AND;
				mips_pkg::FN_OR:  eff_op = mips_pkg::ALU_OR;
				mips_pkg::FN_XOR: eff_op = mips_pkg::ALU_XOR;
				mips_pkg::FN_NOR: eff_op = mips_pkg::ALU_NOR;
				mips_pkg::FN_SLT: eff_op = mips_pkg::ALU_SLT;
				default:          eff_op = mips_pkg::ALU_FUNCT; // unknown funct.
			endcase
		end
	end

	always_comb begin
		case (eff_op)
			mips_pkg::ALU_ADD: result = a + b;
			mips_pkg::ALU_SUB: result = diff;
			mips_pkg::ALU_AND: result = a & b;
			mips_pkg::ALU_OR:  result = a | b;
			mips_pkg::ALU_XOR: result = a ^ b;
			mips_pkg::ALU_NOR: result = ~(a | b);
			mips_pkg::ALU_SLT: begin
				result = '0;
				result[0] = ($signed(a) < $signed(b));
			end
			mips_pkg::ALU_LUI: result = {b[HALF-1:0], {HALF{1'b0}}};
			default:           result = '0; // an unresolved funct gives zero.
		endcase
	end

endmodule

// File: rtl/control.sv
module control (
	input  logic [5:0]      opcode,
	output mips_pkg::ctrl_t ctrl
);

	always_comb begin
		ctrl = '0; // unknown opcodes retire as a no-op.
		case (opcode)
			mips_pkg::OP_RTYPE: begin
				ctrl.regwrite = 1'b1;
				ctrl.regdst   = 1'b1;
				ctrl.alu_op   = mips_pkg::ALU_FUNCT;
			end
			mips_pkg::OP_ADDI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.alu_op   = mips_pkg::ALU_ADD;
			end
			mips_pkg::OP_SLTI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.alu_op   = mips_pkg::ALU_SLT;
			end
			mips_pkg::OP_ANDI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.zero_ext = 1'b1;
				ctrl.alu_op   = mips_pkg::ALU_AND;
			end
			mips_pkg::OP_ORI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.zero_ext = 1'b1;
				ctrl.alu_op   = mips_pkg::ALU_OR;
			end
			mips_pkg::OP_XORI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.zero_ext = 1'b1;
				ctrl.alu_op   = mips_pkg::ALU_XOR;
			end
			mips_pkg::OP_LUI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.alu_op   = mips_pkg::ALU_LUI;
			end
			mips_pkg::OP_LW: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread  = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.alu_op   = mips_pkg::ALU_ADD;
			end
			mips_pkg::OP_SW: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.alu_op   = mips_pkg::ALU_ADD;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				ctrl.isbranch  = 1'b1;
				ctrl.branch_ne = (opcode == mips_pkg::OP_BNE);
				ctrl.alu_op    = mips_pkg::ALU_SUB;
			end
			mips_pkg::OP_J: begin
				ctrl.isjump = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	// ALU_FUNCT hands the choice to the funct field of an R-type word.
	typedef enum logic [3:0] {
		ALU_FUNCT = 4'd0,
		ALU_ADD   = 4'd1,
		ALU_SUB   = 4'd2,
		ALU_AND   = 4'd3,
		ALU_OR    = 4'd4,
		ALU_XOR   = 4'd5,
		ALU_NOR   = 4'd6,
		ALU_SLT   = 4'd7,
		ALU_LUI   = 4'd8
	} alu_op_e;

	typedef struct packed {
		logic    regwrite;
		logic    memtoreg;
		logic    memread;
		logic    memwrite;
		logic    isbranch;
		logic    branch_ne; // branch when the operands differ.
		logic    regdst;    // rd is the destination, else rt.
		logic    alusrc;    // immediate feeds the b operand.
		logic    zero_ext;
		logic    isjump;
		alu_op_e alu_op;
	} ctrl_t;

	// one retired register write, seen the cycle after the instruction.
	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       data;
	} commit_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] addr; // byte address.
		logic [XLEN-1:0] data;
	} store_t;

endpackage
